// File: vector_alu.f
common/vec_pkg.sv
vector_alu/lane_alu.sv
source/vector_issue.sv
source/vector_store.sv
vector_alu/vector_alu.sv
bench/vector_alu_checker.sv
bench/vector_alu_monitor.sv
bench/vector_alu_tb.sv

// File: bench/vector_alu_tb.sv
module vector_alu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int addr_width = 12;
	localparam int row_count = 14;

	logic clk, reset, start, broadcast, busy, mem_write, done;
	vec_pkg::op_t op;
	vec_pkg::vector_word_t src_a, src_b, result_vector;
	logic [addr_width-1:0] memory_base, mem_address;
	logic [31:0] mem_data;

	// Expectations handed to the monitor
	logic row_end, exp_store;
	int test_id, error_count, test_count, seed;
	vec_pkg::vector_word_t exp_vector;
	logic [addr_width-1:0] exp_base;

	// Stimulus table
	logic [3:0] row_op [row_count];
	logic row_bcast [row_count];
	logic row_retry [row_count];
	vec_pkg::vector_word_t row_a [row_count];
	vec_pkg::vector_word_t row_b [row_count];
	vec_pkg::vector_word_t row_expect [row_count];
	logic [addr_width-1:0] row_base [row_count];

	vector_alu #(.addr_width(addr_width)) dut_i (
		.clk(clk), .reset(reset), .start(start), .op(op), .broadcast(broadcast),
		.src_a(src_a), .src_b(src_b), .memory_base(memory_base), .busy(busy),
		.result_vector(result_vector), .mem_write(mem_write), .mem_address(mem_address),
		.mem_data(mem_data), .done(done)
	);

	vector_alu_monitor #(.addr_width(addr_width)) monitor_i (
		.clk(clk), .reset(reset), .busy(busy), .result_vector(result_vector),
		.mem_write(mem_write), .mem_address(mem_address), .mem_data(mem_data), .done(done),
		.row_end(row_end), .test_id(test_id), .exp_vector(exp_vector), .exp_base(exp_base),
		.exp_store(exp_store), .error_count(error_count), .test_count(test_count)
	);

	always #50 clk = ~clk;

	function automatic logic [7:0] expected_lane(input logic [3:0] code, input logic [7:0] a,
		input logic [7:0] b);
		int sum;
		sum = a + b;
		case (code)
			4'd1: return 8'(sum);
			4'd2: return 8'(a - b);
			4'd3: return a & b;
			4'd4: return a | b;
			4'd5: return a ^ b;
			4'd6: return 8'(a << b[2:0]);
			4'd7: return a >> b[2:0];
			4'd8: return (sum > 255) ? 8'hff : 8'(sum);
			4'd9: return (a < b) ? a : b;
			4'd10: return (a > b) ? a : b;
			4'd11: return b;
			default: return 8'h00;
		endcase
	endfunction

	function automatic vec_pkg::vector_word_t expected_vector(input logic [3:0] code,
		input logic bcast, input vec_pkg::vector_word_t a, input vec_pkg::vector_word_t b);
		vec_pkg::vector_word_t v;
		for (int i = 0; i < vec_pkg::lane_count; i++) begin
			v.lanes[i] = expected_lane(code, a.lanes[i], bcast ? b.lanes[0] : b.lanes[i]);
		end
		return v;
	endfunction

	task automatic set_row(input int idx, input logic [3:0] code, input logic bcast,
		input logic retry, input logic [127:0] a, input logic [127:0] b,
		input logic [addr_width-1:0] base, input logic [127:0] want);
		row_op[idx] = code;
		row_bcast[idx] = bcast;
		row_retry[idx] = retry;
		row_a[idx] = a;
		row_b[idx] = b;
		row_base[idx] = base;
		row_expect[idx] = want;
	endtask

	task automatic random_row(input int idx, input logic [3:0] code, input logic bcast);
		logic [127:0] a;
		logic [127:0] b;
		logic [31:0] r;
		a = {$random(seed), $random(seed), $random(seed), $random(seed)};
		b = {$random(seed), $random(seed), $random(seed), $random(seed)};
		r = $random(seed);
		set_row(idx, code, bcast, 1'b0, a, b, r[addr_width-1:0], expected_vector(code, bcast, a, b));
	endtask

	task automatic fill_table();
		set_row(0, vec_pkg::op_add, 0, 0, 128'h80808080_80808080_80808080_80808080,
			128'h00112233_44556677_8899aabb_ccddeeff, 12'h100, 128'h8091a2b3_c4d5e6f7_08192a3b_4c5d6e7f);
		set_row(1, vec_pkg::op_sub, 0, 0, 128'h00112233_44556677_8899aabb_ccddeeff,
			128'h40404040_40404040_40404040_40404040, 12'h200, 128'hc0d1e2f3_04152637_48596a7b_8c9daebf);
		set_row(2, vec_pkg::op_and, 0, 0, 128'hffff0000_ffff0000_12345678_9abcdef0,
			128'h0f0f0f0f_f0f0f0f0_ffffffff_00ff00ff, 12'hff8, 128'h0f0f0000_f0f00000_12345678_00bc00f0);
		set_row(3, vec_pkg::op_or, 0, 0, 128'h11111111_22222222_44444444_88888888,
			128'h01020304_10203040_00000000_f0f0f0f0, 12'h010, 128'h11131315_32223262_44444444_f8f8f8f8);
		set_row(4, vec_pkg::op_xor, 1, 0, 128'h00112233_44556677_8899aabb_ccddeeff,
			128'h12345678_9abcdef0_0f1e2d3c_4b5a69a5, 12'h300, 128'ha5b48796_e1f0c3d2_2d3c0f1e_69784b5a);
		// Dropped request, result from the previous test stays
		set_row(5, vec_pkg::op_nop, 0, 0, {16{8'hff}},
			{16{8'hff}}, 12'h400, 128'ha5b48796_e1f0c3d2_2d3c0f1e_69784b5a);
		set_row(6, 4'd13, 0, 0, {16{8'hff}}, {16{8'hff}}, 12'h500, 128'h0);
		set_row(7, vec_pkg::op_add, 1, 1, 128'h0f0e0d0c_0b0a0908_07060504_03020100,
			128'hffffffff_ffffffff_ffffffff_ffffff01, 12'hffc, 128'h100f0e0d_0c0b0a09_08070605_04030201);
		random_row(8, vec_pkg::op_shl, 0);
		random_row(9, vec_pkg::op_shr, 0);
		random_row(10, vec_pkg::op_adds, 0);
		random_row(11, vec_pkg::op_min, 0);
		random_row(12, vec_pkg::op_max, 0);
		random_row(13, vec_pkg::op_passb, 1);
	endtask

	task automatic finish_row();
		row_end = 1'b1;
		@(negedge clk);
		row_end = 1'b0;
	endtask

	task automatic run_row(input int idx);
		op = vec_pkg::op_t'(row_op[idx]);
		broadcast = row_bcast[idx];
		src_a = row_a[idx];
		src_b = row_b[idx];
		memory_base = row_base[idx];
		exp_vector = row_expect[idx];
		exp_base = row_base[idx];
		exp_store = (row_op[idx] != 4'd0);
		test_id = idx + 1;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (row_retry[idx]) begin
			// Second start while the first request is in the lanes
			op = vec_pkg::op_sub;
			src_a = ~row_a[idx];
			broadcast = 1'b0;
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		if (exp_store) begin
			while (done !== 1'b1) @(negedge clk);
			@(negedge clk);
		end else begin
			repeat (8) @(negedge clk);
		end
		finish_row();
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		op = vec_pkg::op_nop;
		broadcast = 1'b0;
		src_a = '0;
		src_b = '0;
		memory_base = '0;
		row_end = 1'b0;
		test_id = 0;
		exp_vector = '0;
		exp_base = '0;
		exp_store = 1'b0;
		seed = 44;
		fill_table();
		repeat (5) @(negedge clk);
		reset = 1'b0;
		// Idle outputs straight after reset
		repeat (2) @(negedge clk);
		finish_row();
		for (int i = 0; i < row_count; i++) begin
			run_row(i);
		end
		$display("Tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Reset plus a generous budget of cycles per test
	initial begin
		#((5 + 12 * (row_count + 1)) * 100);
		$display("Timeout: the tests did not finish in time, counted as a failure");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: bench/vector_alu_monitor.sv
module vector_alu_monitor #(
	parameter int addr_width = 12
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    busy,
	input  vec_pkg::vector_word_t   result_vector,
	input  logic                    mem_write,
	input  logic [addr_width-1:0]   mem_address,
	input  logic [31:0]             mem_data,
	input  logic                    done,
	input  logic                    row_end,
	input  int                      test_id,
	input  vec_pkg::vector_word_t   exp_vector,
	input  logic [addr_width-1:0]   exp_base,
	input  logic                    exp_store,
	output int                      error_count,
	output int                      test_count
);
	timeunit 1ns;
	timeprecision 100ps;

	int write_count;
	int done_count;
	int busy_count;
	int row_errors;
	logic [addr_width-1:0] want_address;

	task automatic value_error(input string name, input logic [127:0] want, input logic [127:0] got);
		$display("Error at %0d ns: %s expected %0h, got %0h", $time, name, want, got);
		row_errors++;
		error_count++;
	endtask

	task automatic plain_error(input string what);
		$display("Error at %0d ns: %s", $time, what);
		row_errors++;
		error_count++;
	endtask

	initial begin
		error_count = 0;
		test_count = 0;
	end

	// Outputs sampled at the rising edge, so they hold last cycle's values
	always @(posedge clk) begin
		if (reset) begin
			write_count = 0;
			done_count = 0;
			busy_count = 0;
			row_errors = 0;
		end else begin
			// Busy covers the issue cycle, the lane cycle and words 0 to 2
			if (busy)
				busy_count++;
			if (done) begin
				if (!mem_write || write_count != 3)
					plain_error("done pulsed outside the last memory write");
				done_count++;
			end
			if (mem_write) begin
				// Byte address steps by four and wraps at the top
				want_address = exp_base + addr_width'(4 * write_count);
				if (!exp_store || write_count > 3) begin
					plain_error($sformatf("unexpected memory write to address %0h", mem_address));
				end else begin
					if (mem_address !== want_address)
						value_error("mem_address", want_address, mem_address);
					if (mem_data !== exp_vector.words[write_count])
						value_error("mem_data", exp_vector.words[write_count], mem_data);
				end
				write_count++;
			end
			if (row_end) begin
				if (write_count != (exp_store ? 4 : 0))
					plain_error($sformatf("test made %0d memory writes instead of %0d",
						write_count, exp_store ? 4 : 0));
				if (done_count != (exp_store ? 1 : 0))
					plain_error($sformatf("done pulsed %0d times", done_count));
				if (busy_count != (exp_store ? 5 : 0))
					plain_error($sformatf("busy was high for %0d cycles instead of %0d",
						busy_count, exp_store ? 5 : 0));
				if (busy !== 1'b0)
					value_error("busy", 0, busy);
				if (result_vector !== exp_vector)
					value_error("result_vector", exp_vector, result_vector);
				if (row_errors == 0)
					$display("Test %0d: ok", test_id);
				else
					$display("Test %0d: %0d errors", test_id, row_errors);
				test_count++;
				write_count = 0;
				done_count = 0;
				busy_count = 0;
				row_errors = 0;
			end
		end
	end

endmodule

// File: bench/vector_alu_checker.sv
module vector_alu_checker (
	input logic clk,
	input logic reset,
	input logic lane_valid,
	input logic mem_write,
	input logic done,
	input logic busy
);
	timeunit 1ns;
	timeprecision 100ps;

	// Done belongs to the fourth write after the lanes answered
	done_with_write: assert property (@(posedge clk) disable iff (reset)
		done |-> mem_write && $past(lane_valid, 4))
		else $error("done raised outside the last memory write");

	// One vector always goes out as four back to back writes
	four_writes: assert property (@(posedge clk) disable iff (reset)
		lane_valid |=> mem_write [*4] ##1 !mem_write)
		else $error("memory write burst is not four cycles long");

	idle_after_reset: assert property (@(posedge clk) reset |=> !busy)
		else $error("busy is high right after reset");

endmodule

bind vector_store vector_alu_checker checker_i (
	.clk        (clk),
	.reset      (reset),
	.lane_valid (lane_valid),
	.mem_write  (mem_write),
	.done       (done),
	.busy       (busy)
);

// File: vector_alu/vector_alu.sv
module vector_alu #(
	parameter int addr_width = 12
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start,
	input  vec_pkg::op_t            op,
	input  logic                    broadcast,
	input  vec_pkg::vector_word_t   src_a,
	input  vec_pkg::vector_word_t   src_b,
	input  logic [addr_width-1:0]   memory_base,
	output logic                    busy,
	output vec_pkg::vector_word_t   result_vector,
	output logic                    mem_write,
	output logic [addr_width-1:0]   mem_address,
	output logic [31:0]             mem_data,
	output logic                    done
);

	// Issue stage to lanes
	logic                    issue_valid;
	vec_pkg::op_t            lane_op;
	vec_pkg::vector_word_t   lane_a;
	vec_pkg::vector_word_t   lane_b;
	logic [addr_width-1:0]   base_address;

	// Lanes to store stage
	vec_pkg::vector_word_t          lane_results;
	logic [vec_pkg::lane_count-1:0] lane_valid;

	vector_issue #(
		.addr_width(addr_width)
	) issue_i (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.op           (op),
		.broadcast    (broadcast),
		.src_a        (src_a),
		.src_b        (src_b),
		.memory_base  (memory_base),
		.busy         (busy),
		.issue_valid  (issue_valid),
		.lane_op      (lane_op),
		.lane_a       (lane_a),
		.lane_b       (lane_b),
		.base_address (base_address)
	);

	// One byte ALU per lane, all sharing the same operation
	for (genvar i = 0; i < vec_pkg::lane_count; i++) begin : gen_lane
		lane_alu lane_i (
			.clk         (clk),
			.reset       (reset),
			.issue_valid (issue_valid),
			.op          (lane_op),
			.a           (lane_a.lanes[i]),
			.b           (lane_b.lanes[i]),
			.result      (lane_results.lanes[i]),
			.lane_valid  (lane_valid[i])
		);
	end

	// All lanes run in lockstep so lane 0 speaks for the vector
	vector_store #(
		.addr_width(addr_width)
	) store_i (
		.clk           (clk),
		.reset         (reset),
		.issue_valid   (issue_valid),
		.lane_valid    (lane_valid[0]),
		.lanes         (lane_results),
		.base_address  (base_address),
		.busy          (busy),
		.result_vector (result_vector),
		.mem_write     (mem_write),
		.mem_address   (mem_address),
		.mem_data      (mem_data),
		.done          (done)
	);

endmodule

// File: source/vector_store.sv
module vector_store #(
	parameter int addr_width = 12
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    issue_valid,
	input  logic                    lane_valid,
	input  vec_pkg::vector_word_t   lanes,
	input  logic [addr_width-1:0]   base_address,
	output logic                    busy,
	output vec_pkg::vector_word_t   result_vector,
	output logic                    mem_write,
	output logic [addr_width-1:0]   mem_address,
	output logic [31:0]             mem_data,
	output logic                    done
);

	localparam int index_width = $clog2(vec_pkg::word_count);
	localparam logic [index_width-1:0] last_word = index_width'(vec_pkg::word_count - 1);
	localparam logic [addr_width-1:0] addr_step = addr_width'(vec_pkg::word_bytes);

	logic [index_width-1:0] word_index;
	logic                   store_busy;

	// Busy also covers the issue cycle, before the lanes have answered
	assign busy = issue_valid || store_busy;

	// Current word straight out of the captured vector
	assign mem_data = result_vector.words[word_index];
	assign done = mem_write && (word_index == last_word);

	always_ff @(posedge clk) begin
		if (reset) begin
			result_vector <= '0;
			mem_write     <= 1'b0;
			mem_address   <= '0;
			word_index    <= '0;
		end else if (lane_valid) begin
			result_vector <= lanes;
			mem_write     <= 1'b1;
			mem_address   <= base_address;
			word_index    <= '0;
		end else if (mem_write) begin
			if (word_index == last_word) begin
				mem_write <= 1'b0;
			end else begin
				// Address wraps at the top of memory
				word_index  <= word_index + 1'b1;
				mem_address <= mem_address + addr_step;
			end
		end
	end

	// Drops one word early, so the next start lines up as the last write ends
	always_ff @(posedge clk) begin
		if (reset) begin
			store_busy <= 1'b0;
		end else if (issue_valid) begin
			store_busy <= 1'b1;
		end else if (mem_write && (word_index == last_word - 1'b1)) begin
			store_busy <= 1'b0;
		end
	end

endmodule

// File: source/vector_issue.sv
module vector_issue #(
	parameter int addr_width = 12
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start,
	input  vec_pkg::op_t            op,
	input  logic                    broadcast,
	input  vec_pkg::vector_word_t   src_a,
	input  vec_pkg::vector_word_t   src_b,
	input  logic [addr_width-1:0]   memory_base,
	input  logic                    busy,
	output logic                    issue_valid,
	output vec_pkg::op_t            lane_op,
	output vec_pkg::vector_word_t   lane_a,
	output vec_pkg::vector_word_t   lane_b,
	output logic [addr_width-1:0]   base_address
);

	logic                  accept;
	vec_pkg::vector_word_t operand_b;

	// A nop or a start during a running request is simply ignored
	assign accept = start && !busy && (op != vec_pkg::op_nop);

	// Scalar broadcast copies lane 0 of B everywhere
	always_comb begin
		operand_b = src_b;
		if (broadcast) begin
			for (int i = 0; i < vec_pkg::lane_count; i++) begin
				operand_b.lanes[i] = src_b.lanes[0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= accept;
		end
	end

	// Operands and base stay put until the next accepted start
	always_ff @(posedge clk) begin
		if (accept) begin
			lane_op      <= op;
			lane_a       <= src_a;
			lane_b       <= operand_b;
			base_address <= memory_base;
		end
	end

endmodule

// File: vector_alu/lane_alu.sv
module lane_alu (
	input  logic               clk,
	input  logic               reset,
	input  logic               issue_valid,
	input  vec_pkg::op_t       op,
	input  logic [7:0]         a,
	input  logic [7:0]         b,
	output logic [7:0]         result,
	output logic               lane_valid
);

	logic [7:0] next_result;
	logic [8:0] wide_sum;
	logic [2:0] shift_amount;

	// Carry out drives the saturating add
	assign wide_sum = {1'b0, a} + {1'b0, b};

	// Only the low 3 bits of B count as a shift distance
	assign shift_amount = b[2:0];

	always_comb begin
		case (op)
			vec_pkg::op_add:   next_result = a + b;
			vec_pkg::op_sub:   next_result = a - b;
			vec_pkg::op_and:   next_result = a & b;
			vec_pkg::op_or:    next_result = a | b;
			vec_pkg::op_xor:   next_result = a ^ b;
			vec_pkg::op_shl:   next_result = a << shift_amount;
			vec_pkg::op_shr:   next_result = a >> shift_amount;
			vec_pkg::op_adds:  next_result = wide_sum[8] ? 8'hff : wide_sum[7:0];
			vec_pkg::op_min:   next_result = (a < b) ? a : b;
			vec_pkg::op_max:   next_result = (a > b) ? a : b;
			vec_pkg::op_passb: next_result = b;
			// nop and the spare codes
			default:           next_result = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lane_valid <= 1'b0;
		end else begin
			lane_valid <= issue_valid;
		end
	end

	// Result holds between operations
	always_ff @(posedge clk) begin
		if (issue_valid) begin
			result <= next_result;
		end
	end

endmodule

// File: common/vec_pkg.sv
package vec_pkg;

	// Lane geometry, fixed by the vector word layout below
	localparam int lane_count = 16;
	localparam int lane_width = 8;
	localparam int vector_width = lane_count * lane_width;

	// Memory side of the vector
	localparam int word_width = 32;
	localparam int word_count = vector_width / word_width;
	localparam int word_bytes = word_width / 8;

	// Lane operation codes
	// Codes 12 to 15 are unassigned and give a zero lane
	typedef enum logic [3:0] {
		op_nop   = 4'd0,
		op_add   = 4'd1,
		op_sub   = 4'd2,
		op_and   = 4'd3,
		op_or    = 4'd4,
		op_xor   = 4'd5,
		op_shl   = 4'd6,
		op_shr   = 4'd7,
		op_adds  = 4'd8,
		op_min   = 4'd9,
		op_max   = 4'd10,
		op_passb = 4'd11
	} op_t;

	// One 128-bit vector, seen either as bytes or as memory words
	// Lane 0 and word 0 both sit at the low end
	typedef union packed {
		logic [lane_count-1:0][lane_width-1:0] lanes;
		logic [word_count-1:0][word_width-1:0] words;
	} vector_word_t;

endpackage
